// ==== rtl/element_counter.sv ====
// Vector element counter.
// Latches one instruction and walks its elements from vstart to vl,
// NUM_LANES at a time. Each cycle it sends one group with its offset,
// lane mask and last flag. A group never crosses a register boundary,
// the register step trims it and moves the offset to the next register.
`timescale 1ns/1ps

module element_counter import vec_pkg::*; #(
  parameter int NUM_LANES = 2
) (
  input  logic         CLK,
  input  logic         nRST,
  input  logic         start,
  input  vinstr_t      instr,
  output logic         busy,
  vec_stage_if.src     grp
);

  vinstr_t              instr_q;
  offset_t              offset;
  offset_t              next_offset;
  offset_t              epr;
  offset_t              room;
  logic                 step;
  logic                 last;
  logic [MAX_LANES-1:0] mask;
  elem_grp_t            grp_next;

  // ====================
  // Group arithmetic.
  // ====================
  always_comb begin
    epr = elems_per_reg(instr_q.sew);
    // Elements left before the end of the current register.
    room = epr - (offset & (epr - offset_t'(1)));
    // The group reaches the register end, so the next offset steps over.
    step = (room <= offset_t'(NUM_LANES));
    if (step) begin
      next_offset = offset + room;
    end else begin
      next_offset = offset + offset_t'(NUM_LANES);
    end
    last = (next_offset >= instr_q.vl);
    // Trim at the lane count, the register end and vl.
    for (int l = 0; l < MAX_LANES; l++) begin
      mask[l] = (l < NUM_LANES) && (offset_t'(l) < room) &&
                ((offset + offset_t'(l)) < instr_q.vl);
    end
  end

  // Group for fetch.
  always_comb begin
    grp_next           = '0;
    grp_next.offset    = offset;
    grp_next.sew       = instr_q.sew;
    grp_next.op        = instr_q.op;
    grp_next.vd        = instr_q.vd;
    grp_next.lane_mask = mask;
    grp_next.last      = last;
    // Source register numbers ride in the first data words until fetch.
    grp_next.a_data[0] = 32'(instr_q.vs1);
    grp_next.b_data[0] = 32'(instr_q.vs2);
  end

  // ====================
  // Control.
  // ====================
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy      <= 1'b0;
      offset    <= '0;
      grp.valid <= 1'b0;
      grp.last  <= 1'b0;
    end else begin
      grp.valid <= 1'b0;
      grp.last  <= 1'b0;
      if (!busy) begin
        // Start is only taken while idle.
        if (start) begin
          busy   <= 1'b1;
          offset <= instr.vstart;
        end
      end else if (offset < instr_q.vl) begin
        grp.valid <= 1'b1;
        grp.last  <= last;
        offset    <= next_offset;
        if (last) begin
          busy <= 1'b0;
        end
      end else begin
        // Empty instruction, vstart at or past vl.
        busy <= 1'b0;
      end
    end
  end

  // Instruction latch.
  always_ff @(posedge CLK) begin
    if (!busy && start) begin
      instr_q <= instr;
    end
  end

  // Group payload.
  always_ff @(posedge CLK) begin
    grp.payload <= grp_next;
  end

endmodule

// ==== rtl/lane_alu.sv ====
// Lane ALU stage.
// Applies add, sub, and or xor to every active lane, cuts each result
// to the element width and registers the group for write-back. The
// result lands in a_data.
`timescale 1ns/1ps

module lane_alu import vec_pkg::*; #(
  parameter int NUM_LANES = 2
) (
  input  logic     CLK,
  input  logic     nRST,
  vec_stage_if.dst grp_in,
  vec_stage_if.src grp_out
);

  elem_grp_t res;

  // ====================
  // Per-lane compute.
  // ====================
  always_comb begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    res        = grp_in.payload;
    res.a_data = '0;
    res.b_data = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      a = grp_in.payload.a_data[l];
      b = grp_in.payload.b_data[l];
      case (grp_in.payload.op)
        VADD:    r = a + b;
        VSUB:    r = a - b;
        VAND:    r = a & b;
        default: r = a ^ b;
      endcase
      // Wrap to sew bits.
      case (grp_in.payload.sew)
        SEW8:    r = {24'b0, r[7:0]};
        SEW16:   r = {16'b0, r[15:0]};
        default: r = r;
      endcase
      if (grp_in.payload.lane_mask[l]) begin
        res.a_data[l] = r;
      end
    end
  end

  // Strobe and last.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      grp_out.valid <= 1'b0;
      grp_out.last  <= 1'b0;
    end else begin
      grp_out.valid <= grp_in.valid;
      grp_out.last  <= grp_in.last;
    end
  end

  // Result group.
  always_ff @(posedge CLK) begin
    grp_out.payload <= res;
  end

endmodule

// ==== rtl/operand_fetch.sv ====
// Operand fetch stage.
// Picks the register of each source group for the current offset, reads
// both from the register file and extracts the active elements,
// zero-extended to 32 bits. The filled group leaves one cycle later.
`timescale 1ns/1ps

module operand_fetch import vec_pkg::*; #(
  parameter int NUM_LANES = 2
) (
  input  logic       CLK,
  input  logic       nRST,
  vec_stage_if.dst   grp_in,
  vec_stage_if.src   grp_out,
  output vreg_t      rd_reg_a,
  output vreg_t      rd_reg_b,
  input  vreg_data_t rd_data_a,
  input  vreg_data_t rd_data_b
);

  logic      hi_reg;
  elem_grp_t filled;

  // One element out of a register.
  function automatic logic [31:0] get_elem(
    input vreg_data_t data,
    input sew_t       sew,
    input logic [3:0] idx
  );
    case (sew)
      SEW8:    return 32'(data[idx*8 +: 8]);
      SEW16:   return 32'(data[idx[2:0]*16 +: 16]);
      default: return data[idx[1:0]*32 +: 32];
    endcase
  endfunction

  // ====================
  // Register select.
  // ====================
  always_comb begin
    // Register step taken here once the offset passes the first register.
    hi_reg   = (grp_in.payload.offset >= elems_per_reg(grp_in.payload.sew));
    rd_reg_a = {grp_in.payload.a_data[0][2:1], hi_reg};
    rd_reg_b = {grp_in.payload.b_data[0][2:1], hi_reg};
  end

  // ====================
  // Element extract.
  // ====================
  always_comb begin
    logic [3:0] idx;
    filled        = grp_in.payload;
    filled.a_data = '0;
    filled.b_data = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      idx = 4'(grp_in.payload.offset + offset_t'(l));
      if (grp_in.payload.lane_mask[l]) begin
        filled.a_data[l] = get_elem(rd_data_a, grp_in.payload.sew, idx);
        filled.b_data[l] = get_elem(rd_data_b, grp_in.payload.sew, idx);
      end
    end
  end

  // Strobe and last.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      grp_out.valid <= 1'b0;
      grp_out.last  <= 1'b0;
    end else begin
      grp_out.valid <= grp_in.valid;
      grp_out.last  <= grp_in.last;
    end
  end

  // Filled group.
  always_ff @(posedge CLK) begin
    grp_out.payload <= filled;
  end

endmodule

// ==== rtl/vec_pkg.sv ====
// Vector unit shared definitions.
// Element width and operation codes, register geometry, the instruction
// word and the element group that moves between pipeline stages.
package vec_pkg;

  // ====================
  // Geometry.
  // ====================
  localparam int VLEN       = 128;
  localparam int NUM_VREGS  = 8;
  localparam int GROUP_REGS = 2;
  localparam int MAX_LANES  = 4;

  // ====================
  // Field types.
  // ====================
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  typedef enum logic [1:0] {
    VADD = 2'd0,
    VSUB = 2'd1,
    VAND = 2'd2,
    VXOR = 2'd3
  } vop_t;

  // Offsets run 0 to 32 over a two-register group.
  typedef logic [5:0]      offset_t;
  typedef logic [2:0]      vreg_t;
  typedef logic [VLEN-1:0] vreg_data_t;

  typedef struct packed {
    vop_t    op;
    sew_t    sew;
    offset_t vl;
    offset_t vstart;
    vreg_t   vs1;
    vreg_t   vs2;
    vreg_t   vd;
  } vinstr_t;

  // One group of up to MAX_LANES elements.
  typedef struct packed {
    offset_t                        offset;
    sew_t                           sew;
    vop_t                           op;
    vreg_t                          vd;
    logic [MAX_LANES-1:0]           lane_mask;
    logic [MAX_LANES-1:0][31:0]     a_data;
    logic [MAX_LANES-1:0][31:0]     b_data;
    logic                           last;
  } elem_grp_t;

  // Elements held by one 128-bit register at a given width.
  function automatic offset_t elems_per_reg(input sew_t sew);
    case (sew)
      SEW8:    return offset_t'(16);
      SEW16:   return offset_t'(8);
      default: return offset_t'(4);
    endcase
  endfunction

endpackage

// ==== rtl/vec_stage_if.sv ====
// Pipeline stage link.
// Carries one element group per strobe from one stage to the next.
// There is no ready signal, the receiver takes every valid group.
`timescale 1ns/1ps

interface vec_stage_if #(
  parameter type PAYLOAD_T = logic
) ();

  // Single-cycle group strobe.
  logic     valid;
  // Group contents.
  PAYLOAD_T payload;
  // Final group of the instruction.
  logic     last;

  // Sending stage.
  modport src (
    output valid,
    output payload,
    output last
  );

  // Receiving stage.
  modport dst (
    input valid,
    input payload,
    input last
  );

endinterface

// ==== rtl/vec_unit_top.sv ====
// Vector element sequencer top level.
// Counter, operand fetch and lane ALU in a three-stage pipeline around
// the vector register file. Results are also shown on the res ports,
// one group per strobe.
`timescale 1ns/1ps

module vec_unit_top import vec_pkg::*; #(
  parameter int NUM_LANES = 2
) (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       start,
  input  vop_t                       instr_op,
  input  sew_t                       instr_sew,
  input  offset_t                    instr_vl,
  input  offset_t                    instr_vstart,
  input  vreg_t                      instr_vs1,
  input  vreg_t                      instr_vs2,
  input  vreg_t                      instr_vd,
  output logic                       busy,
  output logic                       res_valid,
  output offset_t                    res_offset,
  output logic [NUM_LANES-1:0][31:0] res_data,
  output logic [NUM_LANES-1:0]       res_mask,
  output logic                       res_last,
  input  logic                       pre_we,
  input  vreg_t                      pre_reg,
  input  vreg_data_t                 pre_data,
  input  vreg_t                      dbg_reg,
  output vreg_data_t                 dbg_data
);

  vinstr_t    instr_word;
  vreg_t      rd_reg_a;
  vreg_t      rd_reg_b;
  vreg_data_t rd_data_a;
  vreg_data_t rd_data_b;

  // ====================
  // Stage links.
  // ====================
  vec_stage_if #(.PAYLOAD_T(elem_grp_t)) cnt_to_fetch ();
  vec_stage_if #(.PAYLOAD_T(elem_grp_t)) fetch_to_alu ();
  vec_stage_if #(.PAYLOAD_T(elem_grp_t)) alu_to_wb ();

  // Instruction word from the flat fields.
  always_comb begin
    instr_word.op     = instr_op;
    instr_word.sew    = instr_sew;
    instr_word.vl     = instr_vl;
    instr_word.vstart = instr_vstart;
    instr_word.vs1    = instr_vs1;
    instr_word.vs2    = instr_vs2;
    instr_word.vd     = instr_vd;
  end

  // ====================
  // Pipeline.
  // ====================
  element_counter #(.NUM_LANES(NUM_LANES)) element_counter_inst (
    .CLK   (CLK),
    .nRST  (nRST),
    .start (start),
    .instr (instr_word),
    .busy  (busy),
    .grp   (cnt_to_fetch.src)
  );

  operand_fetch #(.NUM_LANES(NUM_LANES)) operand_fetch_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .grp_in    (cnt_to_fetch.dst),
    .grp_out   (fetch_to_alu.src),
    .rd_reg_a  (rd_reg_a),
    .rd_reg_b  (rd_reg_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b)
  );

  lane_alu #(.NUM_LANES(NUM_LANES)) lane_alu_inst (
    .CLK     (CLK),
    .nRST    (nRST),
    .grp_in  (fetch_to_alu.dst),
    .grp_out (alu_to_wb.src)
  );

  vreg_file vreg_file_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .rd_reg_a  (rd_reg_a),
    .rd_reg_b  (rd_reg_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wb        (alu_to_wb.dst),
    .pre_we    (pre_we),
    .pre_reg   (pre_reg),
    .pre_data  (pre_data),
    .dbg_reg   (dbg_reg),
    .dbg_data  (dbg_data)
  );

  // Result ports.
  assign res_valid  = alu_to_wb.valid;
  assign res_offset = alu_to_wb.payload.offset;
  assign res_data   = alu_to_wb.payload.a_data[NUM_LANES-1:0];
  assign res_mask   = alu_to_wb.payload.lane_mask[NUM_LANES-1:0];
  assign res_last   = alu_to_wb.last;

endmodule

// ==== rtl/vreg_file.sv ====
// Vector register file.
// Eight 128-bit registers with two combinational read ports, a
// lane-masked element write-back port and a whole-register preload and
// readback port for the testbench.
`timescale 1ns/1ps

module vreg_file import vec_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  vreg_t      rd_reg_a,
  input  vreg_t      rd_reg_b,
  output vreg_data_t rd_data_a,
  output vreg_data_t rd_data_b,
  vec_stage_if.dst   wb,
  input  logic       pre_we,
  input  vreg_t      pre_reg,
  input  vreg_data_t pre_data,
  input  vreg_t      dbg_reg,
  output vreg_data_t dbg_data
);

  vreg_data_t                regs [NUM_VREGS];
  vreg_t                     wr_reg;
  logic [MAX_LANES-1:0][3:0] wr_idx;

  // ====================
  // Read ports.
  // ====================
  assign rd_data_a = regs[rd_reg_a];
  assign rd_data_b = regs[rd_reg_b];
  assign dbg_data  = regs[dbg_reg];

  // ====================
  // Write-back target.
  // ====================
  always_comb begin
    // Upper register of the group once the offset passes the first.
    wr_reg = {wb.payload.vd[2:1],
              wb.payload.offset >= elems_per_reg(wb.payload.sew)};
    // Element slot inside the register, the low bits matter per sew.
    for (int l = 0; l < MAX_LANES; l++) begin
      wr_idx[l] = 4'(wb.payload.offset + offset_t'(l));
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int v = 0; v < NUM_VREGS; v++) begin
        regs[v] <= '0;
      end
    end else begin
      if (pre_we) begin
        regs[pre_reg] <= pre_data;
      end
      if (wb.valid) begin
        for (int l = 0; l < MAX_LANES; l++) begin
          // Masked-off lanes leave tail and prestart elements alone.
          if (wb.payload.lane_mask[l]) begin
            case (wb.payload.sew)
              SEW8:  regs[wr_reg][wr_idx[l]*8 +: 8] <= wb.payload.a_data[l][7:0];
              SEW16: regs[wr_reg][wr_idx[l][2:0]*16 +: 16] <= wb.payload.a_data[l][15:0];
              default: regs[wr_reg][wr_idx[l][1:0]*32 +: 32] <= wb.payload.a_data[l];
            endcase
          end
        end
      end
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds and runs the vector unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_vec_unit \
  -f tb.f -Mdir obj_dir -o tb_vec_unit
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_vec_unit > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

# Pass only if the testbench reported it.
if grep -q "^Simulation PASSED$" sim.log; then
  exit 0
fi
exit 1

// ==== sim/vec_ref.svh ====
// Reference model of the vector element sequencer.
// Keeps its own copy of the register file and predicts the result groups
// and the register contents that one instruction leaves behind.
`ifndef VEC_REF_SVH
`define VEC_REF_SVH

// Model register file, follows every preload.
vreg_data_t model_regs [NUM_VREGS];
// Result groups still expected from the DUT, oldest first.
elem_grp_t  exp_q [$];

// Element width in bits.
function automatic int elem_bits(input sew_t sew);
  case (sew)
    SEW8:    return 8;
    SEW16:   return 16;
    default: return 32;
  endcase
endfunction

// Element e of the register group that starts at base.
function automatic logic [31:0] read_elem(input int base, input int e, input sew_t sew);
  int         w;
  int         epr;
  vreg_data_t r;
  w   = elem_bits(sew);
  epr = VLEN / w;
  r   = model_regs[base + e / epr] >> ((e % epr) * w);
  return r[31:0] & 32'((64'd1 << w) - 64'd1);
endfunction

function automatic void write_elem(input int base, input int e, input sew_t sew,
                                   input logic [31:0] v);
  int w;
  int epr;
  int pos;
  w   = elem_bits(sew);
  epr = VLEN / w;
  pos = (e % epr) * w;
  for (int b = 0; b < w; b++) begin
    model_regs[base + e / epr][pos + b] = v[b];
  end
endfunction

// Executes one instruction on the model and queues its result groups.
// Returns the number of groups.
function automatic int ref_exec(input vinstr_t ins);
  int          w;
  int          epr;
  int          o;
  int          n;
  int          count;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] r;
  logic [31:0] res [32];
  elem_grp_t   g;
  w     = elem_bits(ins.sew);
  epr   = VLEN / w;
  count = 0;
  // Sources are read before any destination element changes.
  for (int e = int'(ins.vstart); e < int'(ins.vl); e++) begin
    a = read_elem({ins.vs1[2:1], 1'b0}, e, ins.sew);
    b = read_elem({ins.vs2[2:1], 1'b0}, e, ins.sew);
    case (ins.op)
      VADD:    r = a + b;
      VSUB:    r = a - b;
      VAND:    r = a & b;
      default: r = a ^ b;
    endcase
    res[e] = r & 32'((64'd1 << w) - 64'd1);
  end
  for (int e = int'(ins.vstart); e < int'(ins.vl); e++) begin
    write_elem({ins.vd[2:1], 1'b0}, e, ins.sew, res[e]);
  end
  // Groups stop at the end of a register, then step into the next one.
  o = ins.vstart;
  while (o < int'(ins.vl)) begin
    n = epr - (o % epr);
    if (n > NUM_LANES) begin
      n = NUM_LANES;
    end
    g        = '0;
    g.offset = offset_t'(o);
    for (int l = 0; l < n; l++) begin
      if (o + l < int'(ins.vl)) begin
        g.lane_mask[l] = 1'b1;
        g.a_data[l]    = res[o + l];
      end
    end
    o      = o + n;
    g.last = (o >= int'(ins.vl));
    exp_q.push_back(g);
    count++;
  end
  return count;
endfunction

`endif

// ==== sim/tb_vec_unit.sv ====
// Testbench for the vector element sequencer.
// Preloads the register file, runs vector instructions through the DUT
// and compares every result group and the register state afterwards
// with a reference model.
`timescale 1ns/1ps

module tb_vec_unit import vec_pkg::*; ();

  localparam int NUM_LANES = 2;

  logic                       CLK;
  logic                       nRST;
  logic                       start;
  vop_t                       instr_op;
  sew_t                       instr_sew;
  offset_t                    instr_vl;
  offset_t                    instr_vstart;
  vreg_t                      instr_vs1;
  vreg_t                      instr_vs2;
  vreg_t                      instr_vd;
  logic                       busy;
  logic                       res_valid;
  offset_t                    res_offset;
  logic [NUM_LANES-1:0][31:0] res_data;
  logic [NUM_LANES-1:0]       res_mask;
  logic                       res_last;
  logic                       pre_we;
  vreg_t                      pre_reg;
  vreg_data_t                 pre_data;
  vreg_t                      dbg_reg;
  vreg_data_t                 dbg_data;

  integer seed;
  int     errors;
  int     checks;
  int     tests;
  int     test_errs;
  string  test_name;

  `include "vec_ref.svh"

  vec_unit_top #(.NUM_LANES(NUM_LANES)) vec_unit_top_inst (
    .CLK          (CLK),
    .nRST         (nRST),
    .start        (start),
    .instr_op     (instr_op),
    .instr_sew    (instr_sew),
    .instr_vl     (instr_vl),
    .instr_vstart (instr_vstart),
    .instr_vs1    (instr_vs1),
    .instr_vs2    (instr_vs2),
    .instr_vd     (instr_vd),
    .busy         (busy),
    .res_valid    (res_valid),
    .res_offset   (res_offset),
    .res_data     (res_data),
    .res_mask     (res_mask),
    .res_last     (res_last),
    .pre_we       (pre_we),
    .pre_reg      (pre_reg),
    .pre_data     (pre_data),
    .dbg_reg      (dbg_reg),
    .dbg_data     (dbg_data)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // ====================
  // Compare tasks.
  // ====================
  task automatic check_group(input elem_grp_t exp, input elem_grp_t got);
    string exp_s;
    string got_s;
    checks++;
    if (exp !== got) begin
      errors++;
      exp_s = $sformatf("off %0d mask %b data %h last %b",
                        exp.offset, exp.lane_mask, exp.a_data, exp.last);
      got_s = $sformatf("off %0d mask %b data %h last %b",
                        got.offset, got.lane_mask, got.a_data, got.last);
      $display("** Error %s: group expected %s actual %s", test_name, exp_s, got_s);
    end
  endtask

  task automatic check_vreg(input vreg_t r, input vreg_data_t exp, input vreg_data_t got);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("** Error %s: v%0d expected %h actual %h", test_name, r, exp, got);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic got);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("** Error %s: %s expected %b actual %b", test_name, what, exp, got);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timeout in test %s: %s", test_name, what);
  endtask

  // Result groups are captured at mid-cycle.
  always @(negedge CLK) begin
    elem_grp_t got;
    if (nRST && res_valid) begin
      got        = '0;
      got.offset = res_offset;
      got.last   = res_last;
      for (int l = 0; l < NUM_LANES; l++) begin
        got.lane_mask[l] = res_mask[l];
        if (res_mask[l]) begin
          got.a_data[l] = res_data[l];
        end
      end
      if (exp_q.size() == 0) begin
        errors++;
        $display("Test %s: result group at offset %0d arrived but none was expected",
                 test_name, res_offset);
      end else begin
        check_group(exp_q.pop_front(), got);
      end
    end
  end

  // ====================
  // Stimulus helpers.
  // ====================
  function automatic vreg_data_t rand_vreg();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic vinstr_t make_instr(input vop_t op, input sew_t sew, input int vl,
                                         input int vstart, input int vs1, input int vs2,
                                         input int vd);
    vinstr_t ins;
    ins.op     = op;
    ins.sew    = sew;
    ins.vl     = offset_t'(vl);
    ins.vstart = offset_t'(vstart);
    ins.vs1    = vreg_t'(vs1);
    ins.vs2    = vreg_t'(vs2);
    ins.vd     = vreg_t'(vd);
    return ins;
  endfunction

  // Whole-register write while the DUT is idle.
  task automatic preload(input vreg_t r, input vreg_data_t d);
    @(posedge CLK);
    pre_we   <= 1'b1;
    pre_reg  <= r;
    pre_data <= d;
    @(posedge CLK);
    pre_we <= 1'b0;
    model_regs[r] = d;
  endtask

  task automatic preload_random();
    for (int r = 0; r < NUM_VREGS; r++) begin
      preload(vreg_t'(r), rand_vreg());
    end
  endtask

  // One-cycle start strobe.
  task automatic issue(input vinstr_t ins);
    @(posedge CLK);
    start        <= 1'b1;
    instr_op     <= ins.op;
    instr_sew    <= ins.sew;
    instr_vl     <= ins.vl;
    instr_vstart <= ins.vstart;
    instr_vs1    <= ins.vs1;
    instr_vs2    <= ins.vs2;
    instr_vd     <= ins.vd;
    @(posedge CLK);
    start <= 1'b0;
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    @(negedge CLK);
    while (!busy && t < 4) begin
      @(negedge CLK);
      t++;
    end
    if (!busy) begin
      report_timeout("busy never rose after start");
    end
    t = 0;
    while (busy && t < 200) begin
      @(negedge CLK);
      t++;
    end
    if (busy) begin
      report_timeout("busy never fell");
    end
  endtask

  // Waits for the last expected group. Its write lands on the next edge.
  task automatic drain();
    int t;
    t = 0;
    while (exp_q.size() != 0 && t < 30) begin
      @(negedge CLK);
      t++;
    end
    if (exp_q.size() != 0) begin
      report_timeout($sformatf("%0d result groups never arrived", exp_q.size()));
      exp_q.delete();
    end
  endtask

  task automatic check_regs();
    for (int r = 0; r < NUM_VREGS; r++) begin
      @(posedge CLK);
      dbg_reg <= vreg_t'(r);
      @(negedge CLK);
      check_vreg(vreg_t'(r), model_regs[r], dbg_data);
    end
  endtask

  task automatic run(input vinstr_t ins);
    void'(ref_exec(ins));
    issue(ins);
    wait_idle();
    drain();
    check_regs();
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = errors;
    tests++;
  endtask

  task automatic end_test();
    if (errors == test_errs) begin
      $display("Test %s: pass", test_name);
    end else begin
      $display("Test %s: fail, %0d errors", test_name, errors - test_errs);
    end
  endtask

  // ====================
  // Test sequence.
  // ====================
  initial begin
    vinstr_t ins;
    seed = 32'h9e0c;
    errors = 0;
    checks = 0;
    tests = 0;
    test_name = "reset";
    nRST = 1'b0;
    start = 1'b0;
    instr_op = VADD;
    instr_sew = SEW8;
    instr_vl = '0;
    instr_vstart = '0;
    instr_vs1 = '0;
    instr_vs2 = '0;
    instr_vd = '0;
    pre_we = 1'b0;
    pre_reg = '0;
    pre_data = '0;
    dbg_reg = '0;
    for (int r = 0; r < NUM_VREGS; r++) begin
      model_regs[r] = '0;
    end
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);

    begin_test("reset");
    check_flag("busy", 1'b0, busy);
    check_flag("res_valid", 1'b0, res_valid);
    end_test();

    // Full register group at every width.
    begin_test("full_sweep");
    preload_random();
    run(make_instr(VADD, SEW8, 32, 0, 0, 2, 4));
    run(make_instr(VSUB, SEW16, 16, 0, 2, 0, 6));
    run(make_instr(VXOR, SEW32, 8, 0, 4, 6, 0));
    end_test();

    // Odd vl leaves a one-lane final group and an untouched tail.
    begin_test("partial_tail");
    preload_random();
    run(make_instr(VADD, SEW16, 7, 0, 0, 2, 4));
    run(make_instr(VAND, SEW8, 13, 0, 2, 4, 6));
    end_test();

    // Odd vstart also forces a one-lane group at a register step.
    begin_test("nonzero_vstart");
    preload_random();
    run(make_instr(VSUB, SEW16, 14, 6, 0, 2, 4));
    run(make_instr(VXOR, SEW8, 29, 5, 2, 6, 0));
    run(make_instr(VADD, SEW32, 8, 3, 0, 2, 6));
    end_test();

    // All ones plus anything overflows and zero minus anything underflows.
    begin_test("ops_wraparound");
    preload_random();
    preload(3'd0, '1);
    preload(3'd1, '1);
    run(make_instr(VADD, SEW8, 32, 0, 0, 2, 4));
    run(make_instr(VADD, SEW32, 8, 0, 0, 2, 6));
    preload(3'd0, '0);
    preload(3'd1, '0);
    run(make_instr(VSUB, SEW16, 16, 0, 0, 2, 4));
    run(make_instr(VSUB, SEW8, 32, 0, 0, 2, 6));
    run(make_instr(VAND, SEW32, 8, 0, 2, 4, 0));
    run(make_instr(VXOR, SEW16, 16, 0, 6, 2, 4));
    end_test();

    // Empty instructions and then a start while busy that must be dropped.
    begin_test("empty_and_busy_start");
    preload_random();
    run(make_instr(VADD, SEW16, 6, 10, 0, 2, 4));
    run(make_instr(VXOR, SEW8, 12, 12, 0, 2, 6));
    check_flag("busy", 1'b0, busy);
    ins = make_instr(VADD, SEW8, 32, 0, 0, 2, 4);
    void'(ref_exec(ins));
    issue(ins);
    issue(make_instr(VXOR, SEW32, 8, 0, 0, 2, 6));
    wait_idle();
    drain();
    check_regs();
    end_test();

    // Each start follows the fall of busy with groups still in flight.
    begin_test("back_to_back");
    preload_random();
    ins = make_instr(VADD, SEW16, 16, 0, 0, 2, 4);
    void'(ref_exec(ins));
    issue(ins);
    wait_idle();
    ins = make_instr(VSUB, SEW8, 32, 0, 0, 2, 6);
    void'(ref_exec(ins));
    issue(ins);
    wait_idle();
    ins = make_instr(VAND, SEW32, 8, 0, 2, 0, 4);
    void'(ref_exec(ins));
    issue(ins);
    wait_idle();
    drain();
    check_regs();
    end_test();

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+sim
rtl/vec_pkg.sv
rtl/vec_stage_if.sv
rtl/element_counter.sv
rtl/vreg_file.sv
rtl/operand_fetch.sv
rtl/lane_alu.sv
rtl/vec_unit_top.sv
sim/tb_vec_unit.sv
